// File: lm80c_defines.svh
// ***********************************************************
// Shared macros for the LM80C system glue
// Bus widths, RAM write window, I/O port numbers,
// clock-enable divider length and audio widths
// ***********************************************************
`ifndef LM80C_DEFINES_SVH
`define LM80C_DEFINES_SVH

// Bus widths
`define LM80C_ADDR_W 16
`define LM80C_DATA_W 8

// CPU-writable RAM window, both ends inclusive
`define LM80C_RAM_LO 16'h8000
`define LM80C_RAM_HI 16'hBFFF

// Upper nibble of the I/O address for each peripheral
`define LM80C_PORT_PIO 4'd0
`define LM80C_PORT_CTC 4'd1
`define LM80C_PORT_SIO 4'd2
`define LM80C_PORT_VDP 4'd3
`define LM80C_PORT_PSG 4'd4

// Debug LED port and its value after reset
`define LM80C_PORT_LED 8'd255
`define LM80C_LED_INIT 8'd1

// Clock-enable divider length, in ram_clock cycles
`define LM80C_ENA_PERIOD 16

// Sound channel and modulator widths
`define LM80C_CHAN_W 8
`define LM80C_DAC_W 16

`endif

// File: lm80c_pkg.sv
// ***********************************************************
// Package with the shared vector types of the glue logic
// and the state encoding of the RAM eraser
// ***********************************************************
`default_nettype none

`include "lm80c_defines.svh"

package lm80c_pkg;

	// CPU address and data bus
	typedef logic [`LM80C_ADDR_W-1:0] addr_t;
	typedef logic [`LM80C_DATA_W-1:0] byte_t;

	// One PSG channel level
	typedef logic [`LM80C_CHAN_W-1:0] chan_t;

	// Sum of three channels, two extra bits of headroom
	typedef logic [`LM80C_CHAN_W+1:0] mix_t;

	// Modulator input word
	typedef logic [`LM80C_DAC_W-1:0] dac_t;

	// Eraser FSM
	typedef enum logic {
		ERASE_IDLE,
		ERASE_RUN
	} erase_state_t;

endpackage

`default_nettype wire

// File: sys_control.sv
// ***********************************************************
// Clock enables for the Z80 and the PSG
// System reset and CPU wait levels
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "lm80c_defines.svh"

module sys_control (
	input  wire ram_clock,
	input  wire RESET,
	input  wire boot_done_i,
	input  wire reset_key_i,
	input  wire loader_active_i,
	input  wire erase_busy_i,
	output logic z80_ena_o,
	output logic psg_ena_o,
	output logic sys_reset_o,
	output logic cpu_wait_o
);

	localparam int PERIOD = `LM80C_ENA_PERIOD;
	localparam int CNT_W = $clog2(PERIOD);

	logic [CNT_W-1:0] cnt_q;

	// Free-running divider, enables registered so they are low in reset
	// Enables land on counts 0 and PERIOD/2
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cnt_q <= '0;
			z80_ena_o <= 1'b0;
			psg_ena_o <= 1'b0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
			z80_ena_o <= (cnt_q == CNT_W'(PERIOD - 1)) || (cnt_q == CNT_W'(PERIOD / 2 - 1));
			psg_ena_o <= (cnt_q == CNT_W'(PERIOD - 1));
		end
	end

	// Peripherals held in reset while booting, on the key, or while erasing
	assign sys_reset_o = ~boot_done_i | reset_key_i | erase_busy_i;
	// CPU stalled while booting, loading or erasing
	assign cpu_wait_o = ~boot_done_i | loader_active_i | erase_busy_i;

	// PSG tick always shares a Z80 tick, and the next Z80 tick is half a period on
	a_psg_in_z80: assert property (@(posedge ram_clock) disable iff (RESET)
		psg_ena_o |-> z80_ena_o ##(PERIOD / 2) z80_ena_o)
		else $error("psg_ena_o not aligned to z80_ena_o");

endmodule

`default_nettype wire

// File: bus_decoder.sv
// ***********************************************************
// Registered decode of the Z80 bus
// Peripheral selects, read and INTA qualifiers,
// VDP and PSG strobes, RAM write requests
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "lm80c_defines.svh"

module bus_decoder (
	input  wire ram_clock,
	input  wire RESET,
	input  lm80c_pkg::addr_t cpu_addr_i,
	input  wire cpu_rd_n_i,
	input  wire cpu_wr_n_i,
	input  wire cpu_iorq_n_i,
	input  wire cpu_mreq_n_i,
	input  wire cpu_m1_n_i,
	output logic ctc_sel_o,
	output logic vdp_sel_o,
	output logic psg_sel_o,
	output logic led_sel_o,
	output logic io_read_o,
	output logic inta_o,
	output logic led_wr_o,
	output logic ram_wr_o,
	output logic vdp_csr_n_o,
	output logic vdp_csw_n_o,
	output logic psg_bdir_o,
	output logic psg_bc_o
);

	import lm80c_pkg::*;

	byte_t io_port;
	logic rd, wr, io_cyc, mem_cyc;
	logic ctc_hit, vdp_hit, psg_hit, led_hit, ram_hit;

	// I/O addresses use only the low byte
	assign io_port = cpu_addr_i[7:0];
	assign rd = ~cpu_rd_n_i;
	assign wr = ~cpu_wr_n_i;
	// I/O needs IORQ without MREQ
	assign io_cyc = ~cpu_iorq_n_i & cpu_mreq_n_i;
	assign mem_cyc = ~cpu_mreq_n_i & cpu_iorq_n_i;

	assign ctc_hit = io_cyc & (io_port[7:4] == `LM80C_PORT_CTC);
	assign vdp_hit = io_cyc & (io_port[7:4] == `LM80C_PORT_VDP);
	assign psg_hit = io_cyc & (io_port[7:4] == `LM80C_PORT_PSG);
	assign led_hit = io_cyc & (io_port == `LM80C_PORT_LED);
	// Only the window above the ROM image is writable
	assign ram_hit = mem_cyc & (cpu_addr_i >= `LM80C_RAM_LO) & (cpu_addr_i <= `LM80C_RAM_HI);

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			ctc_sel_o <= 1'b0;
			vdp_sel_o <= 1'b0;
			psg_sel_o <= 1'b0;
			led_sel_o <= 1'b0;
			io_read_o <= 1'b0;
			inta_o <= 1'b0;
			led_wr_o <= 1'b0;
			ram_wr_o <= 1'b0;
			vdp_csr_n_o <= 1'b1;
			vdp_csw_n_o <= 1'b1;
			psg_bdir_o <= 1'b0;
			psg_bc_o <= 1'b0;
		end else begin
			ctc_sel_o <= ctc_hit;
			vdp_sel_o <= vdp_hit;
			psg_sel_o <= psg_hit;
			led_sel_o <= led_hit;
			io_read_o <= rd & io_cyc;
			// Interrupt acknowledge is IORQ during M1
			inta_o <= ~cpu_iorq_n_i & ~cpu_m1_n_i;
			led_wr_o <= wr & led_hit;
			ram_wr_o <= wr & ram_hit;
			// VDP chip strobes, active low
			vdp_csr_n_o <= ~(rd & vdp_hit);
			vdp_csw_n_o <= ~(wr & vdp_hit);
			// PSG bus control, BC1 picks the register address port
			psg_bdir_o <= wr & psg_hit;
			psg_bc_o <= psg_hit & ~io_port[0];
		end
	end

	a_sel_onehot: assert property (@(posedge ram_clock) disable iff (RESET)
		$onehot0({ctc_sel_o, vdp_sel_o, psg_sel_o, led_sel_o}))
		else $error("peripheral selects not one-hot");

endmodule

`default_nettype wire

// File: ram_eraser.sv
// ***********************************************************
// RAM eraser, zeroes all 64 KiB one byte per cycle
// after a rising edge of the hard-reset request
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module ram_eraser (
	input  wire ram_clock,
	input  wire RESET,
	input  wire hard_reset_i,
	output logic erase_busy_o,
	output logic erase_wr_o,
	output lm80c_pkg::addr_t erase_addr_o
);

	import lm80c_pkg::*;

	erase_state_t state_q;
	addr_t addr_q;
	logic hard_d_q;
	logic start;

	// Edge detect, a held request starts one pass only
	assign start = hard_reset_i & ~hard_d_q;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			state_q <= ERASE_IDLE;
			addr_q <= '0;
			hard_d_q <= 1'b0;
		end else begin
			hard_d_q <= hard_reset_i;
			case (state_q)
				ERASE_IDLE: begin
					if (start) begin
						state_q <= ERASE_RUN;
					end
				end
				ERASE_RUN: begin
					// Counter wraps back to 0 on the last byte
					addr_q <= addr_q + 1'b1;
					if (addr_q == '1) begin
						state_q <= ERASE_IDLE;
					end
				end
				default: state_q <= ERASE_IDLE;
			endcase
		end
	end

	assign erase_busy_o = (state_q == ERASE_RUN);
	// One write per busy cycle
	assign erase_wr_o = erase_busy_o;
	assign erase_addr_o = addr_q;

	a_idle_addr_zero: assert property (@(posedge ram_clock) disable iff (RESET)
		(state_q == ERASE_IDLE) |-> (addr_q == '0))
		else $error("eraser address not zero while idle");

endmodule

`default_nettype wire

// File: mem_arbiter.sv
// ***********************************************************
// RAM port arbiter
// Fixed priority: ROM loader, then eraser, then CPU
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire ram_clock,
	input  wire RESET,
	input  wire loader_active_i,
	input  wire loader_wr_i,
	input  lm80c_pkg::addr_t loader_addr_i,
	input  lm80c_pkg::byte_t loader_data_i,
	input  wire erase_busy_i,
	input  wire erase_wr_i,
	input  lm80c_pkg::addr_t erase_addr_i,
	input  lm80c_pkg::addr_t cpu_addr_i,
	input  lm80c_pkg::byte_t cpu_data_i,
	input  wire ram_wr_i,
	output lm80c_pkg::addr_t ram_addr_o,
	output lm80c_pkg::byte_t ram_data_o,
	output logic ram_we_o
);

	import lm80c_pkg::*;

	// Address and data mux, no reset needed
	always_ff @(posedge ram_clock) begin
		if (loader_active_i) begin
			ram_addr_o <= loader_addr_i;
			ram_data_o <= loader_data_i;
		end else if (erase_busy_i) begin
			ram_addr_o <= erase_addr_i;
			// Eraser always clears
			ram_data_o <= byte_t'(0);
		end else begin
			ram_addr_o <= cpu_addr_i;
			ram_data_o <= cpu_data_i;
		end
	end

	// Write enable follows the same priority
	// CPU writes dropped while loader or eraser own the port
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			ram_we_o <= 1'b0;
		end else if (loader_active_i) begin
			ram_we_o <= loader_wr_i;
		end else if (erase_busy_i) begin
			ram_we_o <= erase_wr_i;
		end else begin
			ram_we_o <= ram_wr_i;
		end
	end

	a_no_idle_write: assert property (@(posedge ram_clock) disable iff (RESET)
		!(loader_active_i && loader_wr_i) && !(erase_busy_i && erase_wr_i) && !ram_wr_i
		|=> !ram_we_o)
		else $error("RAM write with every source idle");

endmodule

`default_nettype wire

// File: sys_ram.sv
// ***********************************************************
// 64 KiB system RAM, single port, registered read
// Read-during-write returns the old byte
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module sys_ram (
	input  wire ram_clock,
	input  lm80c_pkg::addr_t ram_addr_i,
	input  lm80c_pkg::byte_t ram_data_i,
	input  wire ram_we_i,
	output lm80c_pkg::byte_t ram_q_o
);

	import lm80c_pkg::*;

	localparam int DEPTH = 2 ** $bits(addr_t);

	byte_t mem [0:DEPTH-1];

	// Old data out on a write, maps onto a block RAM
	always_ff @(posedge ram_clock) begin
		if (ram_we_i) begin
			mem[ram_addr_i] <= ram_data_i;
		end
		ram_q_o <= mem[ram_addr_i];
	end

endmodule

`default_nettype wire

// File: bus_readback.sv
// ***********************************************************
// LED port latch and the CPU read-data register
// Peripheral bytes, INTA vector and RAM data
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "lm80c_defines.svh"

module bus_readback (
	input  wire ram_clock,
	input  wire RESET,
	input  wire ctc_sel_i,
	input  wire vdp_sel_i,
	input  wire psg_sel_i,
	input  wire led_sel_i,
	input  wire io_read_i,
	input  wire inta_i,
	input  wire led_wr_i,
	input  lm80c_pkg::byte_t cpu_data_i,
	input  lm80c_pkg::byte_t ctc_data_i,
	input  lm80c_pkg::byte_t vdp_data_i,
	input  lm80c_pkg::byte_t psg_data_i,
	input  lm80c_pkg::byte_t ram_q_i,
	output lm80c_pkg::byte_t led_o,
	output lm80c_pkg::byte_t cpu_data_o
);

	import lm80c_pkg::*;

	byte_t led_q;

	// Debug LED latch on port 255
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			led_q <= `LM80C_LED_INIT;
		end else if (led_wr_i) begin
			led_q <= cpu_data_i;
		end
	end

	assign led_o = led_q;

	// Byte presented to the CPU data bus
	always_ff @(posedge ram_clock) begin
		if (inta_i) begin
			// CTC supplies the interrupt vector
			cpu_data_o <= ctc_data_i;
		end else if (io_read_i) begin
			if (ctc_sel_i) begin
				cpu_data_o <= ctc_data_i;
			end else if (vdp_sel_i) begin
				cpu_data_o <= vdp_data_i;
			end else if (psg_sel_i) begin
				cpu_data_o <= psg_data_i;
			end else if (led_sel_i) begin
				cpu_data_o <= led_q;
			end else begin
				// PIO, SIO and unmapped ports read as zero
				cpu_data_o <= byte_t'(0);
			end
		end else begin
			cpu_data_o <= ram_q_i;
		end
	end

endmodule

`default_nettype wire

// File: audio_dac.sv
// ***********************************************************
// PSG channel mixer and first-order sigma-delta DAC
// Mix, accumulate and output stages, one cycle each
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module audio_dac (
	input  wire ram_clock,
	input  wire RESET,
	input  lm80c_pkg::chan_t chan_a_i,
	input  lm80c_pkg::chan_t chan_b_i,
	input  lm80c_pkg::chan_t chan_c_i,
	output logic audio_l_o,
	output logic audio_r_o
);

	import lm80c_pkg::*;

	// Zero bits that scale the mix up to full modulator range
	localparam int PAD_W = $bits(dac_t) - $bits(mix_t);

	mix_t mix_q;
	dac_t dac_word;
	logic [$bits(dac_t):0] acc_q;

	assign dac_word = {mix_q, {PAD_W{1'b0}}};

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			mix_q <= '0;
			acc_q <= '0;
			audio_l_o <= 1'b0;
			audio_r_o <= 1'b0;
		end else begin
			mix_q <= mix_t'(chan_a_i) + mix_t'(chan_b_i) + mix_t'(chan_c_i);
			// Carry of the previous sum dropped, kept only as the output bit
			acc_q <= {1'b0, acc_q[$bits(dac_t)-1:0]} + {1'b0, dac_word};
			// Mono source, same stream on both sides
			audio_l_o <= acc_q[$bits(dac_t)];
			audio_r_o <= acc_q[$bits(dac_t)];
		end
	end

endmodule

`default_nettype wire

// File: lm80c_glue_top.sv
// ***********************************************************
// LM80C system glue top level
// Clocking and reset, bus decode, RAM path, readback, audio
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

module lm80c_glue_top (
	input  wire ram_clock,
	input  wire RESET,
	// Z80 bus
	input  lm80c_pkg::addr_t cpu_addr_i,
	input  lm80c_pkg::byte_t cpu_data_i,
	input  wire cpu_rd_n_i,
	input  wire cpu_wr_n_i,
	input  wire cpu_iorq_n_i,
	input  wire cpu_mreq_n_i,
	input  wire cpu_m1_n_i,
	output lm80c_pkg::byte_t cpu_data_o,
	// ROM loader
	input  wire loader_active_i,
	input  wire loader_wr_i,
	input  lm80c_pkg::addr_t loader_addr_i,
	input  lm80c_pkg::byte_t loader_data_i,
	input  wire boot_done_i,
	input  wire reset_key_i,
	input  wire hard_reset_i,
	// Peripheral read data
	input  lm80c_pkg::byte_t ctc_data_i,
	input  lm80c_pkg::byte_t vdp_data_i,
	input  lm80c_pkg::byte_t psg_data_i,
	// PSG channels
	input  lm80c_pkg::chan_t chan_a_i,
	input  lm80c_pkg::chan_t chan_b_i,
	input  lm80c_pkg::chan_t chan_c_i,
	output logic z80_ena_o,
	output logic psg_ena_o,
	output logic sys_reset_o,
	output logic cpu_wait_o,
	output logic ctc_sel_o,
	output logic vdp_csr_n_o,
	output logic vdp_csw_n_o,
	output logic psg_bdir_o,
	output logic psg_bc_o,
	output lm80c_pkg::byte_t led_o,
	output logic audio_l_o,
	output logic audio_r_o
);

	import lm80c_pkg::*;

	logic erase_busy, erase_wr;
	addr_t erase_addr;
	logic vdp_sel, psg_sel, led_sel;
	logic io_read, inta, led_wr, ram_wr;
	addr_t ram_addr;
	byte_t ram_data, ram_q;
	logic ram_we;

	sys_control u_sys_control (
		.ram_clock(ram_clock), .RESET(RESET),
		.boot_done_i(boot_done_i), .reset_key_i(reset_key_i),
		.loader_active_i(loader_active_i), .erase_busy_i(erase_busy),
		.z80_ena_o(z80_ena_o), .psg_ena_o(psg_ena_o),
		.sys_reset_o(sys_reset_o), .cpu_wait_o(cpu_wait_o)
	);

	// Decode stage
	bus_decoder u_bus_decoder (
		.ram_clock(ram_clock), .RESET(RESET), .cpu_addr_i(cpu_addr_i),
		.cpu_rd_n_i(cpu_rd_n_i), .cpu_wr_n_i(cpu_wr_n_i),
		.cpu_iorq_n_i(cpu_iorq_n_i), .cpu_mreq_n_i(cpu_mreq_n_i), .cpu_m1_n_i(cpu_m1_n_i),
		.ctc_sel_o(ctc_sel_o), .vdp_sel_o(vdp_sel), .psg_sel_o(psg_sel), .led_sel_o(led_sel),
		.io_read_o(io_read), .inta_o(inta), .led_wr_o(led_wr), .ram_wr_o(ram_wr),
		.vdp_csr_n_o(vdp_csr_n_o), .vdp_csw_n_o(vdp_csw_n_o),
		.psg_bdir_o(psg_bdir_o), .psg_bc_o(psg_bc_o)
	);

	ram_eraser u_ram_eraser (
		.ram_clock(ram_clock), .RESET(RESET), .hard_reset_i(hard_reset_i),
		.erase_busy_o(erase_busy), .erase_wr_o(erase_wr), .erase_addr_o(erase_addr)
	);

	// Arbitration stage
	mem_arbiter u_mem_arbiter (
		.ram_clock(ram_clock), .RESET(RESET),
		.loader_active_i(loader_active_i), .loader_wr_i(loader_wr_i),
		.loader_addr_i(loader_addr_i), .loader_data_i(loader_data_i),
		.erase_busy_i(erase_busy), .erase_wr_i(erase_wr), .erase_addr_i(erase_addr),
		.cpu_addr_i(cpu_addr_i), .cpu_data_i(cpu_data_i), .ram_wr_i(ram_wr),
		.ram_addr_o(ram_addr), .ram_data_o(ram_data), .ram_we_o(ram_we)
	);

	sys_ram u_sys_ram (
		.ram_clock(ram_clock), .ram_addr_i(ram_addr), .ram_data_i(ram_data),
		.ram_we_i(ram_we), .ram_q_o(ram_q)
	);

	// Readback stage
	bus_readback u_bus_readback (
		.ram_clock(ram_clock), .RESET(RESET),
		.ctc_sel_i(ctc_sel_o), .vdp_sel_i(vdp_sel), .psg_sel_i(psg_sel), .led_sel_i(led_sel),
		.io_read_i(io_read), .inta_i(inta), .led_wr_i(led_wr), .cpu_data_i(cpu_data_i),
		.ctc_data_i(ctc_data_i), .vdp_data_i(vdp_data_i), .psg_data_i(psg_data_i),
		.ram_q_i(ram_q), .led_o(led_o), .cpu_data_o(cpu_data_o)
	);

	audio_dac u_audio_dac (
		.ram_clock(ram_clock), .RESET(RESET),
		.chan_a_i(chan_a_i), .chan_b_i(chan_b_i), .chan_c_i(chan_c_i),
		.audio_l_o(audio_l_o), .audio_r_o(audio_r_o)
	);

endmodule

`default_nettype wire

// File: tb_lm80c_glue.sv
// ***********************************************************
// Testbench for the LM80C system glue
// Z80 bus and loader stimulus, reference RAM model,
// concurrent checks on enables, data, strobes and audio
// ***********************************************************
`timescale 1ns/1ps
`default_nettype none

`include "lm80c_defines.svh"

module tb_lm80c_glue;

	import lm80c_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int ENA_WIN = 10 * `LM80C_ENA_PERIOD;
	localparam int AUDIO_WIN = 4096;
	localparam int ERASE_LEN = 65536;
	// One full erase plus a few thousand cycles for the other tests
	localparam int CYCLE_LIMIT = 80000;
	// {wait, sys_reset, csr_n, csw_n, bdir, bc, ctc_sel, z80, psg, l, r, led}
	localparam logic [18:0] RESET_STATE = {11'b111_1000_0000, `LM80C_LED_INIT};

	logic ram_clock = 1'b0;
	logic RESET;
	addr_t cpu_addr;
	byte_t cpu_wdata;
	logic cpu_rd_n, cpu_wr_n, cpu_iorq_n, cpu_mreq_n, cpu_m1_n;
	logic loader_active, loader_wr, boot_done, reset_key, hard_reset;
	addr_t loader_addr;
	byte_t loader_data, ctc_data, vdp_data, psg_data;
	chan_t chan_a, chan_b, chan_c;
	byte_t cpu_rdata, led;
	logic z80_ena, psg_ena, sys_reset, cpu_wait, ctc_sel;
	logic vdp_csr_n, vdp_csw_n, psg_bdir, psg_bc, audio_l, audio_r;

	// Check bookkeeping
	string cur_test;
	int err_cnt = 0;
	int chk_cnt = 0;
	int test_err0 = 0;
	logic [31:0] seed = 32'h6a29_8188;
	byte_t ref_mem [0:65535];

	// Check enables, raised for one sample
	logic data_chk = 1'b0;
	logic strobe_chk = 1'b0;
	logic led_chk = 1'b0;
	logic rst_chk = 1'b0;
	logic quiet_chk = 1'b0;
	logic ena_chk = 1'b0;
	logic aud_chk = 1'b0;
	logic aud_zero_chk = 1'b0;
	logic erase_chk = 1'b0;
	byte_t exp_data = '0;
	byte_t exp_led = '0;
	logic [4:0] exp_strobes = '0;
	int exp_ones = 0;

	// Counting window
	logic win_clr = 1'b0;
	logic win_en = 1'b0;
	int z80_cnt = 0;
	int psg_cnt = 0;
	int ones_cnt = 0;
	int busy_cnt = 0;
	int cyc = 0;

	lm80c_glue_top dut (
		.ram_clock(ram_clock), .RESET(RESET),
		.cpu_addr_i(cpu_addr), .cpu_data_i(cpu_wdata),
		.cpu_rd_n_i(cpu_rd_n), .cpu_wr_n_i(cpu_wr_n), .cpu_iorq_n_i(cpu_iorq_n),
		.cpu_mreq_n_i(cpu_mreq_n), .cpu_m1_n_i(cpu_m1_n), .cpu_data_o(cpu_rdata),
		.loader_active_i(loader_active), .loader_wr_i(loader_wr),
		.loader_addr_i(loader_addr), .loader_data_i(loader_data),
		.boot_done_i(boot_done), .reset_key_i(reset_key), .hard_reset_i(hard_reset),
		.ctc_data_i(ctc_data), .vdp_data_i(vdp_data), .psg_data_i(psg_data),
		.chan_a_i(chan_a), .chan_b_i(chan_b), .chan_c_i(chan_c),
		.z80_ena_o(z80_ena), .psg_ena_o(psg_ena), .sys_reset_o(sys_reset),
		.cpu_wait_o(cpu_wait), .ctc_sel_o(ctc_sel), .vdp_csr_n_o(vdp_csr_n),
		.vdp_csw_n_o(vdp_csw_n), .psg_bdir_o(psg_bdir), .psg_bc_o(psg_bc),
		.led_o(led), .audio_l_o(audio_l), .audio_r_o(audio_r)
	);

	always #HALF_PERIOD ram_clock = ~ram_clock;

	// Window counters and the run limit
	always @(posedge ram_clock) begin
		cyc <= cyc + 1;
		if (win_clr) begin
			z80_cnt <= 0;
			psg_cnt <= 0;
			ones_cnt <= 0;
			busy_cnt <= 0;
		end else if (win_en) begin
			z80_cnt <= z80_cnt + (z80_ena ? 1 : 0);
			psg_cnt <= psg_cnt + (psg_ena ? 1 : 0);
			ones_cnt <= ones_cnt + (audio_l ? 1 : 0);
			// Both levels must be held together
			busy_cnt <= busy_cnt + ((sys_reset && cpu_wait) ? 1 : 0);
		end
		if (cyc >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic report_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		err_cnt++;
		$display("Fail %s (%s): expected %0h, actual %0h", cur_test, what, exp, act);
	endtask

	task automatic report_problem(input string msg);
		err_cnt++;
		$display("Error in %s: %s", cur_test, msg);
	endtask

	a_reset_state: assert property (@(posedge ram_clock)
		rst_chk |-> {cpu_wait, sys_reset, vdp_csr_n, vdp_csw_n, psg_bdir, psg_bc, ctc_sel,
			z80_ena, psg_ena, audio_l, audio_r, led} == RESET_STATE)
		else report_value("outputs in reset", 32'(RESET_STATE), 32'($sampled({cpu_wait,
			sys_reset, vdp_csr_n, vdp_csw_n, psg_bdir, psg_bc, ctc_sel, z80_ena, psg_ena,
			audio_l, audio_r, led})));
	a_boot_hold: assert property (@(posedge ram_clock) disable iff (RESET)
		!boot_done |-> sys_reset && cpu_wait)
		else report_problem("reset or wait released before boot done");
	a_loader_wait: assert property (@(posedge ram_clock) disable iff (RESET)
		loader_active |-> cpu_wait)
		else report_problem("CPU not stalled during loader activity");
	a_key_reset: assert property (@(posedge ram_clock) disable iff (RESET)
		reset_key |-> sys_reset)
		else report_problem("reset key did not raise the system reset");
	a_quiet: assert property (@(posedge ram_clock) quiet_chk |-> !sys_reset && !cpu_wait)
		else report_problem("reset or wait high with boot done and nothing busy");
	// Enable spacing, and the count over the window
	a_z80_gap: assert property (@(posedge ram_clock) disable iff (RESET)
		z80_ena |-> ##(`LM80C_ENA_PERIOD / 2) z80_ena)
		else report_problem("z80_ena_o pulses not half a period apart");
	a_psg_gap: assert property (@(posedge ram_clock) disable iff (RESET)
		psg_ena |-> ##(`LM80C_ENA_PERIOD) psg_ena)
		else report_problem("psg_ena_o pulses not one period apart");
	a_psg_on_z80: assert property (@(posedge ram_clock) disable iff (RESET)
		psg_ena |-> z80_ena)
		else report_problem("psg_ena_o high without z80_ena_o");
	a_ena_count: assert property (@(posedge ram_clock)
		ena_chk |-> z80_cnt == 20 && psg_cnt == 10)
		else report_value("z80 and psg pulses in 160 cycles", 32'h0014_000a,
			{16'($sampled(z80_cnt)), 16'($sampled(psg_cnt))});
	a_read_data: assert property (@(posedge ram_clock) data_chk |-> cpu_rdata == exp_data)
		else report_value("read data", 32'($sampled(exp_data)), 32'($sampled(cpu_rdata)));
	a_strobes: assert property (@(posedge ram_clock)
		strobe_chk |-> {vdp_csr_n, vdp_csw_n, psg_bdir, psg_bc, ctc_sel} == exp_strobes)
		else report_value("csr_n csw_n bdir bc ctc_sel", 32'($sampled(exp_strobes)),
			32'($sampled({vdp_csr_n, vdp_csw_n, psg_bdir, psg_bc, ctc_sel})));
	a_led: assert property (@(posedge ram_clock) led_chk |-> led == exp_led)
		else report_value("LED latch", 32'($sampled(exp_led)), 32'($sampled(led)));
	a_audio_zero: assert property (@(posedge ram_clock) aud_zero_chk |-> !audio_l && !audio_r)
		else report_problem("audio output high with silent channels");
	a_audio_lr: assert property (@(posedge ram_clock) disable iff (RESET) audio_l == audio_r)
		else report_problem("left and right audio streams differ");
	a_audio_count: assert property (@(posedge ram_clock)
		aud_chk |-> ones_cnt >= exp_ones - 1 && ones_cnt <= exp_ones + 1)
		else report_value("ones in 4096 cycles", 32'($sampled(exp_ones)),
			32'($sampled(ones_cnt)));
	a_erase_len: assert property (@(posedge ram_clock) erase_chk |-> busy_cnt == ERASE_LEN)
		else report_value("erase busy cycles", 32'(ERASE_LEN), 32'($sampled(busy_cnt)));

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic addr_t rand_addr();
		return addr_t'(next_rand() >> 8);
	endfunction

	function automatic byte_t rand_byte();
		return byte_t'(next_rand() >> 16);
	endfunction

	// Byte a port read returns, by upper nibble
	function automatic byte_t io_reference(input logic [3:0] nib);
		case (nib)
			`LM80C_PORT_CTC: return ctc_data;
			`LM80C_PORT_VDP: return vdp_data;
			`LM80C_PORT_PSG: return psg_data;
			default: return 8'h00;
		endcase
	endfunction

	task automatic start_test(input string name);
		cur_test = name;
		test_err0 = err_cnt;
	endtask

	task automatic end_test();
		$display("Test %s done, %0d errors", cur_test, err_cnt - test_err0);
	endtask

	task automatic open_window();
		@(posedge ram_clock);
		win_clr <= 1'b1;
		@(posedge ram_clock);
		win_clr <= 1'b0;
		win_en <= 1'b1;
	endtask

	// One Z80 bus request, held 6 cycles and checked on the last
	task automatic bus_cycle(input logic is_io, input logic is_wr, input logic is_inta,
			input addr_t addr, input byte_t wdata, input logic check_rd,
			input byte_t expect_rd);
		logic io, rd, vdp, psg, ctc;
		io = is_io | is_inta;
		rd = ~is_wr & ~is_inta;
		vdp = io && (addr[7:4] == `LM80C_PORT_VDP);
		psg = io && (addr[7:4] == `LM80C_PORT_PSG);
		ctc = io && (addr[7:4] == `LM80C_PORT_CTC);
		@(posedge ram_clock);
		cpu_addr <= addr;
		cpu_wdata <= wdata;
		cpu_rd_n <= ~rd;
		cpu_wr_n <= ~is_wr;
		cpu_iorq_n <= ~io;
		cpu_mreq_n <= io;
		cpu_m1_n <= ~is_inta;
		repeat (5) @(posedge ram_clock);
		exp_data <= expect_rd;
		exp_strobes <= {~(vdp & rd), ~(vdp & is_wr), psg & is_wr, psg & ~addr[0], ctc};
		data_chk <= check_rd;
		strobe_chk <= 1'b1;
		chk_cnt += check_rd ? 2 : 1;
		@(posedge ram_clock);
		data_chk <= 1'b0;
		strobe_chk <= 1'b0;
		// Strobes released, address and data held while the decoder drains
		cpu_rd_n <= 1'b1;
		cpu_wr_n <= 1'b1;
		cpu_iorq_n <= 1'b1;
		cpu_mreq_n <= 1'b1;
		cpu_m1_n <= 1'b1;
		repeat (2) @(posedge ram_clock);
	endtask

	task automatic mem_read(input addr_t addr);
		bus_cycle(1'b0, 1'b0, 1'b0, addr, 8'h00, 1'b1, ref_mem[addr]);
	endtask

	// Only the RAM window takes CPU writes
	task automatic mem_write(input addr_t addr, input byte_t data);
		bus_cycle(1'b0, 1'b1, 1'b0, addr, data, 1'b0, 8'h00);
		if (addr >= `LM80C_RAM_LO && addr <= `LM80C_RAM_HI) begin
			ref_mem[addr] = data;
		end
	endtask

	task automatic loader_write(input addr_t addr, input byte_t data);
		@(posedge ram_clock);
		loader_active <= 1'b1;
		loader_wr <= 1'b1;
		loader_addr <= addr;
		loader_data <= data;
		ref_mem[addr] = data;
	endtask

	task automatic loader_stop();
		@(posedge ram_clock);
		loader_active <= 1'b0;
		loader_wr <= 1'b0;
	endtask

	initial begin
		int i;
		int sum;
		addr_t a;
		addr_t held_addr;
		byte_t d;
		addr_t loaded[$];
		RESET = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_rd_n = 1'b1;
		cpu_wr_n = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_mreq_n = 1'b1;
		cpu_m1_n = 1'b1;
		loader_active = 1'b0;
		loader_wr = 1'b0;
		loader_addr = '0;
		loader_data = '0;
		boot_done = 1'b0;
		reset_key = 1'b0;
		hard_reset = 1'b0;
		chan_a = '0;
		chan_b = '0;
		chan_c = '0;
		ctc_data = rand_byte();
		vdp_data = rand_byte();
		psg_data = rand_byte();

		start_test("reset");
		@(posedge ram_clock);
		rst_chk <= 1'b1;
		repeat (RESET_CYCLES - 1) @(posedge ram_clock);
		chk_cnt += RESET_CYCLES - 1;
		RESET <= 1'b0;
		rst_chk <= 1'b0;
		end_test();

		// Boot load with the CPU held, then the reset key
		start_test("boot");
		for (i = 0; i < 4; i++) begin
			a = rand_addr();
			loader_write(a, rand_byte());
			loaded.push_back(a);
		end
		loader_stop();
		repeat (3) @(posedge ram_clock);
		boot_done <= 1'b1;
		quiet_chk <= 1'b1;
		repeat (4) @(posedge ram_clock);
		quiet_chk <= 1'b0;
		reset_key <= 1'b1;
		repeat (3) @(posedge ram_clock);
		reset_key <= 1'b0;
		quiet_chk <= 1'b1;
		repeat (4) @(posedge ram_clock);
		quiet_chk <= 1'b0;
		chk_cnt += 8;
		end_test();

		start_test("enables");
		open_window();
		repeat (ENA_WIN) @(posedge ram_clock);
		win_en <= 1'b0;
		ena_chk <= 1'b1;
		chk_cnt++;
		@(posedge ram_clock);
		ena_chk <= 1'b0;
		end_test();

		// Loader bytes spread over every region, boundaries included
		start_test("memory");
		for (i = 0; i < 12; i++) begin
			a = rand_addr();
			case (i % 4)
				0: a[15] = 1'b0;
				1: a[15:14] = 2'b11;
				2: a[15:14] = 2'b10;
				default: ;
			endcase
			loaded.push_back(a);
		end
		loaded.push_back(16'h7FFF);
		loaded.push_back(`LM80C_RAM_LO);
		loaded.push_back(`LM80C_RAM_HI);
		loaded.push_back(16'hC000);
		for (i = 4; i < loaded.size(); i++) begin
			loader_write(loaded[i], rand_byte());
		end
		loader_stop();
		for (i = 0; i < loaded.size(); i++) begin
			mem_read(loaded[i]);
		end
		// Inverted bytes land only inside the window
		for (i = 0; i < loaded.size(); i++) begin
			mem_write(loaded[i], ~ref_mem[loaded[i]]);
			mem_read(loaded[i]);
		end
		end_test();

		start_test("io");
		exp_led <= `LM80C_LED_INIT;
		led_chk <= 1'b1;
		chk_cnt++;
		@(posedge ram_clock);
		led_chk <= 1'b0;
		for (i = 0; i < 10; i++) begin
			a = rand_addr();
			a[7:4] = 4'(i % 5);
			bus_cycle(1'b1, 1'b0, 1'b0, a, 8'h00, 1'b1, io_reference(a[7:4]));
		end
		d = rand_byte();
		bus_cycle(1'b1, 1'b1, 1'b0, {8'h00, `LM80C_PORT_LED}, d, 1'b0, 8'h00);
		exp_led <= d;
		led_chk <= 1'b1;
		chk_cnt++;
		@(posedge ram_clock);
		led_chk <= 1'b0;
		bus_cycle(1'b1, 1'b0, 1'b0, {8'h00, `LM80C_PORT_LED}, 8'h00, 1'b1, d);
		// Interrupt acknowledge takes the CTC vector
		bus_cycle(1'b0, 1'b0, 1'b1, 16'h0000, 8'h00, 1'b1, ctc_data);
		end_test();

		start_test("strobes");
		bus_cycle(1'b1, 1'b1, 1'b0, 16'h0030, rand_byte(), 1'b0, 8'h00);
		bus_cycle(1'b1, 1'b1, 1'b0, 16'h0031, rand_byte(), 1'b0, 8'h00);
		bus_cycle(1'b1, 1'b1, 1'b0, 16'h0040, rand_byte(), 1'b0, 8'h00);
		bus_cycle(1'b1, 1'b1, 1'b0, 16'h0041, rand_byte(), 1'b0, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b0, 16'h0041, 8'h00, 1'b1, psg_data);
		bus_cycle(1'b1, 1'b0, 1'b0, 16'h0010, 8'h00, 1'b1, ctc_data);
		// Memory cycles on VDP and PSG looking addresses
		bus_cycle(1'b0, 1'b0, 1'b0, 16'h0030, 8'h00, 1'b0, 8'h00);
		bus_cycle(1'b0, 1'b1, 1'b0, 16'h0040, rand_byte(), 1'b0, 8'h00);
		end_test();

		start_test("audio");
		aud_zero_chk <= 1'b1;
		repeat (256) @(posedge ram_clock);
		aud_zero_chk <= 1'b0;
		chk_cnt += 256;
		for (i = 0; i < 2; i++) begin
			chan_a <= rand_byte();
			chan_b <= rand_byte();
			chan_c <= rand_byte();
			@(posedge ram_clock);
			sum = int'(chan_a) + int'(chan_b) + int'(chan_c);
			// Sum widened by six zero bits, carries out of 16 bits
			exp_ones <= (AUDIO_WIN * sum * 64) / 65536;
			repeat (4) @(posedge ram_clock);
			open_window();
			repeat (AUDIO_WIN) @(posedge ram_clock);
			win_en <= 1'b0;
			aud_chk <= 1'b1;
			chk_cnt++;
			@(posedge ram_clock);
			aud_chk <= 1'b0;
		end
		end_test();

		start_test("erase");
		open_window();
		hard_reset <= 1'b1;
		@(posedge ram_clock);
		hard_reset <= 1'b0;
		// Eraser writes address k on cycle k, so it is past the RAM window here
		repeat (int'(`LM80C_RAM_HI) + 16) @(posedge ram_clock);
		// CPU write during the erase is dropped
		held_addr = `LM80C_RAM_LO | (rand_addr() & 16'h3FFF);
		mem_write(held_addr, 8'hA5);
		while (sys_reset) begin
			@(posedge ram_clock);
		end
		win_en <= 1'b0;
		erase_chk <= 1'b1;
		chk_cnt++;
		@(posedge ram_clock);
		erase_chk <= 1'b0;
		for (i = 0; i < 65536; i++) begin
			ref_mem[i] = 8'h00;
		end
		mem_read(held_addr);
		for (i = 0; i < 6; i++) begin
			mem_read(loaded[i]);
			mem_read(rand_addr());
		end
		end_test();

		$display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
lm80c_pkg.sv
sys_control.sv
bus_decoder.sv
ram_eraser.sv
mem_arbiter.sv
sys_ram.sv
bus_readback.sv
audio_dac.sv
lm80c_glue_top.sv
tb_lm80c_glue.sv

// File: Makefile
# Verilator build for the LM80C system glue

VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_lm80c_glue
RTL_TOP    = lm80c_glue_top
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
